// File: exec_top.f
exec_pkg.sv
inst_buffer.sv
inst_decoder.sv
reg_file.sv
alu.sv
credit_counter.sv
issue_fsm.sv
exec_top.sv
tb_exec_top.sv

// File: tb_exec_top.sv
// ====================
// directed testbench for the integer execute stage.
// upstream and downstream credit handling, a shadow register file
// with an ISA reference model, compare tasks and a watchdog.
// ====================

`timescale 1ns/10ps

module tb_exec_top import exec_pkg::*;;

    localparam int BUF_DEPTH   = 4;
    localparam int RES_CREDITS = 2;
    localparam int CLK_PERIOD  = 4;
    localparam int N_STREAM    = 12;
    // loads, reg-reg ops, immediates, divides, back-pressure stream.
    localparam int N_INST         = 16 + 18 + 24 + 11 + N_STREAM;
    localparam int TIMEOUT_CYCLES = N_INST * 20 + 16;

    logic      clk;
    logic      arst_n;
    logic      inst_valid;
    inst_req_t inst_req;
    logic      inst_credit;
    exe_res_t  res;
    logic      res_valid;
    logic      res_credit;

    exe_res_t    exp_q[$];
    logic [31:0] shadow [32];  // r0 is never written.
    logic [31:0] pc;
    int          seed = 45;
    int          sent, returned, received, pending, err_cnt;
    bit          hold_credits;
    bit          stream_done;

    exec_top #(.BUF_DEPTH(BUF_DEPTH), .RES_CREDITS(RES_CREDITS)) i_exec_top (
        .clk_i         (clk),
        .arst_n_i      (arst_n),
        .inst_valid_i  (inst_valid),
        .inst_req_i    (inst_req),
        .inst_credit_o (inst_credit),
        .res_o         (res),
        .res_valid_o   (res_valid),
        .res_credit_i  (res_credit)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // ==================== checks.
    task automatic stop_with_error(input string msg);
        err_cnt++;
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_res(input exe_res_t got, input exe_res_t exp);
        if (got !== exp) begin
            $display("Mismatch res_o: got pc=%h rd=%h value=%h, expected pc=%h rd=%h value=%h",
                     got.pc, got.rd, got.value, exp.pc, exp.rd, exp.value);
            stop_with_error("result differs from the reference model");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            stop_with_error("control output has the wrong level");
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            stop_with_error("event count is wrong");
        end
    endtask

    // ==================== monitors.
    always @(negedge clk) begin
        exe_res_t exp;
        if (arst_n && inst_credit) returned++;
        if (arst_n && res_valid) begin
            if (exp_q.size() == 0) begin
                stop_with_error("result arrived with no instruction outstanding");
            end else begin
                exp = exp_q.pop_front();
                check_res(res, exp);
            end
            received++;
            pending++;
            if (pending > RES_CREDITS) stop_with_error("more results than downstream credits");
        end
    end

    always @(posedge clk) begin
        #1;
        if (!hold_credits && pending > 0) begin
            res_credit = 1'b1;  // one credit back per result.
            pending--;
        end else begin
            res_credit = 1'b0;
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        stop_with_error("timeout, the DUT stopped producing results");
    end

    // ==================== stimulus and reference model.
    // called and returns 1 ns after a rising edge.
    task automatic send_inst(input logic [31:0] inst, input logic [4:0] rd,
                             input logic [31:0] value);
        while (sent - returned >= BUF_DEPTH) begin
            inst_valid = 1'b0;
            @(posedge clk);
            #1;
        end
        exp_q.push_back('{pc: pc, rd: rd, value: value});
        inst_req   = '{inst: inst, pc: pc};
        inst_valid = 1'b1;
        sent++;
        pc = pc + 32'd4;
        if (rd != 5'd0) shadow[rd] = value;
        @(posedge clk);
        #1;
        inst_valid = 1'b0;
    endtask

    function automatic logic [31:0] model_3r(input logic [16:0] op, input logic [31:0] a,
                                             input logic [31:0] b);
        logic signed [63:0] ps;
        logic [63:0]        pu;
        ps = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        pu = {32'd0, a} * {32'd0, b};
        case (op)
            OP_ADD_W:   return a + b;
            OP_SUB_W:   return a - b;
            OP_SLT:     return {31'd0, $signed(a) < $signed(b)};
            OP_SLTU:    return {31'd0, a < b};
            OP_NOR:     return ~(a | b);
            OP_AND:     return a & b;
            OP_OR:      return a | b;
            OP_XOR:     return a ^ b;
            OP_SLL_W:   return a << b[4:0];
            OP_SRL_W:   return a >> b[4:0];
            OP_SRA_W:   return $signed(a) >>> b[4:0];
            OP_MUL_W:   return ps[31:0];
            OP_MULH_W:  return ps[63:32];
            OP_MULH_WU: return pu[63:32];
            OP_DIV_W: begin
                if (b == 0) return '1;
                return $signed(a) / $signed(b);
            end
            OP_MOD_W: begin
                if (b == 0) return '1;
                return $signed(a) % $signed(b);  // sign follows the dividend.
            end
            OP_DIV_WU:  return (b == 0) ? '1 : a / b;
            OP_MOD_WU:  return (b == 0) ? '1 : a % b;
            default:    return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] model_imm12(input logic [9:0] op, input logic [31:0] a,
                                                input logic [11:0] si12);
        logic [31:0] sext, zext;
        sext = {{20{si12[11]}}, si12};
        zext = {20'd0, si12};  // logic immediates are zero extended.
        case (op)
            OP_SLTI:   return {31'd0, $signed(a) < $signed(sext)};
            OP_SLTUI:  return {31'd0, a < sext};
            OP_ADDI_W: return a + sext;
            OP_ANDI:   return a & zext;
            OP_ORI:    return a | zext;
            OP_XORI:   return a ^ zext;
            default:   return 32'd0;
        endcase
    endfunction

    task automatic run_3r(input logic [16:0] op, input logic [4:0] rd, rj, rk);
        send_inst({op, rk, rj, rd}, rd, model_3r(op, shadow[rj], shadow[rk]));
    endtask

    task automatic run_imm12(input logic [9:0] op, input logic [4:0] rd, rj,
                             input logic [11:0] si12);
        send_inst({op, si12, rj, rd}, rd, model_imm12(op, shadow[rj], si12));
    endtask

    task automatic run_shift_imm(input logic [16:0] op, input logic [4:0] rd, rj,
                                 input logic [4:0] ui5);
        logic [31:0] a, value;
        a = shadow[rj];
        case (op)
            OP_SLLI_W: value = a << ui5;
            OP_SRLI_W: value = a >> ui5;
            default:   value = $signed(a) >>> ui5;
        endcase
        send_inst({op, ui5, rj, rd}, rd, value);
    endtask

    task automatic run_imm20(input logic [6:0] op, input logic [4:0] rd, input logic [19:0] si20);
        logic [31:0] value;
        value = {si20, 12'd0};
        if (op == OP_PCADDU12I) value = pc + value;
        send_inst({op, si20, rd}, rd, value);
    endtask

    task automatic drain();
        while (exp_q.size() != 0 || pending != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    // ==================== directed tests.
    task automatic reset_idle();
        repeat (8) begin
            @(negedge clk);
            check_flag("res_valid_o", res_valid, 1'b0);
            check_flag("inst_credit_o", inst_credit, 1'b0);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic reg_reg_ops();
        logic [31:0] val;
        logic [16:0] ops [18];
        ops = '{OP_ADD_W, OP_SUB_W, OP_SLT, OP_SLTU, OP_AND, OP_OR, OP_XOR, OP_NOR,
                OP_SLL_W, OP_SRL_W, OP_SRA_W, OP_MUL_W, OP_MULH_W, OP_MULH_WU,
                OP_DIV_W, OP_MOD_W, OP_DIV_WU, OP_MOD_WU};
        for (int r = 1; r <= 8; r++) begin
            val = $random(seed);
            run_imm20(OP_LU12I_W, 5'(r), val[31:12]);
            run_imm12(OP_ORI, 5'(r), 5'(r), val[11:0]);
        end
        for (int i = 0; i < 18; i++) begin
            run_3r(ops[i], 5'(9 + i), 5'(1 + i % 8), 5'(1 + (i + 3) % 8));
        end
        drain();
    endtask

    task automatic imm_ops();
        logic [9:0]  ops12 [6];
        logic [11:0] imm12 [2];
        logic [19:0] imm20 [2];
        logic [4:0]  sh [2];
        ops12 = '{OP_SLTI, OP_SLTUI, OP_ADDI_W, OP_ANDI, OP_ORI, OP_XORI};
        imm12 = '{12'h7f3, 12'h8a5};  // positive and negative.
        imm20 = '{20'h00123, 20'h80001};
        sh    = '{5'd7, 5'd31};
        for (int k = 0; k < 2; k++) begin
            for (int i = 0; i < 6; i++) begin
                run_imm12(ops12[i], 5'(9 + i), 5'd3, imm12[k]);
            end
            run_shift_imm(OP_SLLI_W, 5'd15, 5'd5, sh[k]);
            run_shift_imm(OP_SRLI_W, 5'd16, 5'd5, sh[k]);
            run_shift_imm(OP_SRAI_W, 5'd17, 5'd5, sh[k]);
            run_imm20(OP_LU12I_W, 5'd18, imm20[k]);
            run_imm20(OP_PCADDU12I, 5'd19, imm20[k]);
        end
        run_imm12(OP_ADDI_W, 5'd0, 5'd1, 12'h123);  // r0 must stay zero.
        run_3r(OP_OR, 5'd20, 5'd0, 5'd0);
        drain();
    endtask

    task automatic divide_ops();
        run_imm20(OP_LU12I_W, 5'd23, 20'hfffff);
        run_imm12(OP_ORI, 5'd23, 5'd23, 12'h123);
        run_imm12(OP_ORI, 5'd24, 5'd0, 12'h007);
        // r0 as divisor.
        run_3r(OP_DIV_W, 5'd25, 5'd23, 5'd0);
        run_3r(OP_DIV_WU, 5'd26, 5'd23, 5'd0);
        run_3r(OP_MOD_W, 5'd27, 5'd23, 5'd0);
        run_3r(OP_MOD_WU, 5'd28, 5'd23, 5'd0);
        run_3r(OP_DIV_W, 5'd25, 5'd23, 5'd24);
        run_3r(OP_DIV_WU, 5'd26, 5'd23, 5'd24);
        run_3r(OP_MOD_W, 5'd27, 5'd23, 5'd24);
        run_3r(OP_MOD_WU, 5'd28, 5'd23, 5'd24);
        drain();
    endtask

    task automatic backpressure();
        int got0, ret0;
        got0         = received;
        ret0         = returned;
        hold_credits = 1'b1;
        stream_done  = 1'b0;
        fork
            begin
                for (int i = 0; i < N_STREAM; i++) begin
                    run_imm12(OP_ADDI_W, 5'd29, 5'd29, 12'(i + 1));
                end
                stream_done = 1'b1;
            end
        join_none
        while (received - got0 < RES_CREDITS || sent - returned < BUF_DEPTH) begin
            @(posedge clk);
            #1;
        end
        repeat (10) @(posedge clk);  // stalled window.
        #1;
        check_count("results while stalled", received - got0, RES_CREDITS);
        check_count("inst_credit_o while stalled", returned - ret0, RES_CREDITS);
        hold_credits = 1'b0;
        while (!stream_done) begin
            @(posedge clk);
            #1;
        end
        drain();
    endtask

    task automatic credit_accounting();
        check_count("inst_credit_o pulses", returned, sent);
    endtask

    initial begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        inst_valid   = 1'b0;
        inst_req     = '0;
        res_credit   = 1'b0;
        hold_credits = 1'b0;
        pc           = 32'h1c00_0000;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = 32'd0;
        end
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;

        reset_idle();
        reg_reg_ops();
        imm_ops();
        divide_ops();
        backpressure();
        credit_accounting();

        if (err_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: exec_top.sv
// ====================
// integer execute stage top level.
// buffer, decoder, register file, ALU, issue FSM and credit counter.
// ====================

`timescale 1ns/10ps

module exec_top import exec_pkg::*; #(
    parameter int BUF_DEPTH   = 4,  // power of two.
    parameter int RES_CREDITS = 2
) (
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      inst_valid_i,
    input  inst_req_t inst_req_i,
    output logic      inst_credit_o,
    output exe_res_t  res_o,
    output logic      res_valid_o,
    input  logic      res_credit_i
);

    inst_req_t        head;
    logic             empty, pop, take, avail, we;
    decode_info_t     decode_info;
    logic [1:0][31:0] reg_fetch;
    logic [31:0]      alu_res;

    inst_buffer #(.BUF_DEPTH(BUF_DEPTH)) i_inst_buffer (
        .clk_i, .arst_n_i, .inst_valid_i, .inst_req_i,
        .pop_i         (pop),
        .head_o        (head),
        .empty_o       (empty),
        .inst_credit_o
    );

    inst_decoder i_inst_decoder (
        .inst_i        (head.inst),
        .decode_info_o (decode_info)
    );

    reg_file i_reg_file (
        .clk_i, .arst_n_i,
        .raddr0_i (decode_info.rj),
        .raddr1_i (decode_info.rk),
        .rdata0_o (reg_fetch[0]),
        .rdata1_o (reg_fetch[1]),
        .we_i     (we),
        .waddr_i  (decode_info.rd),
        .wdata_i  (alu_res)
    );

    alu i_alu (
        .decode_info_i (decode_info),
        .reg_fetch_i   (reg_fetch),
        .pc_i          (head.pc),
        .alu_res_o     (alu_res)
    );

    credit_counter #(.RES_CREDITS(RES_CREDITS)) i_credit_counter (
        .clk_i, .arst_n_i,
        .take_i  (take),
        .give_i  (res_credit_i),
        .avail_o (avail)
    );

    issue_fsm i_issue_fsm (
        .clk_i, .arst_n_i,
        .empty_i       (empty),
        .avail_i       (avail),
        .decode_info_i (decode_info),
        .pc_i          (head.pc),
        .alu_res_i     (alu_res),
        .pop_o         (pop),
        .take_o        (take),
        .we_o          (we),
        .res_o,
        .res_valid_o
    );

endmodule

// File: issue_fsm.sv
// ====================
// issue FSM.
// pops the buffer head, launches the result and writes it back.
// ====================

`timescale 1ns/10ps

module issue_fsm import exec_pkg::*; (
    input  logic         clk_i,
    input  logic         arst_n_i,
    input  logic         empty_i,
    input  logic         avail_i,
    input  decode_info_t decode_info_i,
    input  logic [31:0]  pc_i,
    input  logic [31:0]  alu_res_i,
    output logic         pop_o,
    output logic         take_o,
    output logic         we_o,
    output exe_res_t     res_o,
    output logic         res_valid_o
);

    issue_state_e state_q, state_d;
    logic         issue;

    assign issue  = !empty_i && avail_i;
    assign pop_o  = issue;
    assign take_o = issue;
    assign we_o   = issue && decode_info_i.wb_en && (decode_info_i.rd != 5'd0);

    always_comb begin
        if (empty_i) state_d = ST_IDLE;
        else if (avail_i) state_d = ST_RUN;
        else state_d = ST_STALL;  // head held until a credit returns.
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= ST_IDLE;
            res_valid_o <= 1'b0;
        end else begin
            state_q     <= state_d;
            res_valid_o <= issue;
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue) res_o <= '{pc: pc_i, rd: decode_info_i.rd, value: alu_res_i};
    end

    // a stalled head stays in place for the next cycle.
    a_stall_holds_head: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (state_q == ST_STALL) |-> (!empty_i && $stable(pc_i)));

endmodule

// File: credit_counter.sv
// ====================
// downstream result credit counter.
// ====================

`timescale 1ns/10ps

module credit_counter #(
    parameter int RES_CREDITS = 2
) (
    input  logic clk_i,
    input  logic arst_n_i,
    input  logic take_i,
    input  logic give_i,
    output logic avail_o
);

    localparam int CW = $clog2(RES_CREDITS + 1);

    logic [CW-1:0] cnt_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q <= CW'(RES_CREDITS);
        end else if (take_i && !give_i) begin
            cnt_q <= cnt_q - 1'b1;
        end else if (give_i && !take_i) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign avail_o = (cnt_q != '0);

    // downstream never returns more than it was given.
    a_no_underflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (take_i && !give_i) |-> (cnt_q != '0));
    a_no_overflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (give_i && !take_i) |-> (cnt_q < CW'(RES_CREDITS)));

endmodule

// File: alu.sv
// ====================
// integer ALU.
// operand select, add, compare, logic, shift, multiply and divide.
// ====================

`timescale 1ns/10ps

module alu import exec_pkg::*; (
    input  decode_info_t     decode_info_i,
    input  logic [1:0][31:0] reg_fetch_i,
    input  logic [31:0]      pc_i,
    output logic [31:0]      alu_res_o
);

    alu_type_e   alu_type;
    logic        opd_unsigned;
    logic [25:0] imm;
    logic [31:0] opd1, opd2;
    logic [63:0] prod_s, prod_u;

    assign alu_type     = decode_info_i.alu_type;
    assign opd_unsigned = decode_info_i.opd_unsigned;
    assign imm          = decode_info_i.inst25_0;

    // ==================== operands.
    always_comb begin
        opd1 = reg_fetch_i[0];  // rj.
        case (decode_info_i.opd_type)
            OPD_IMM_U5:  opd2 = {27'd0, imm[14:10]};
            OPD_IMM_S12: opd2 = {{20{imm[21]}}, imm[21:10]};
            OPD_IMM_U12: opd2 = {20'd0, imm[21:10]};
            OPD_IMM_S20: begin
                opd2 = {imm[24:5], 12'd0};
                if (alu_type == ALU_ADD) opd1 = pc_i;  // pcaddu12i.
            end
            default:     opd2 = reg_fetch_i[1];
        endcase
    end

    // ==================== result.
    always_comb begin
        prod_s = $signed(opd1) * $signed(opd2);
        prod_u = opd1 * opd2;
        case (alu_type)
            ALU_ADD: alu_res_o = opd1 + opd2;
            ALU_SUB: alu_res_o = opd1 - opd2;
            ALU_SLT: begin
                if (opd_unsigned) begin
                    alu_res_o = {31'd0, opd1 < opd2};
                end else begin
                    alu_res_o = {31'd0, $signed(opd1) < $signed(opd2)};
                end
            end
            ALU_AND: alu_res_o = opd1 & opd2;
            ALU_OR:  alu_res_o = opd1 | opd2;
            ALU_XOR: alu_res_o = opd1 ^ opd2;
            ALU_NOR: alu_res_o = ~(opd1 | opd2);
            ALU_SL:  alu_res_o = opd1 << opd2[4:0];
            ALU_SR: begin
                if (opd_unsigned) begin
                    alu_res_o = opd1 >> opd2[4:0];
                end else begin
                    alu_res_o = $signed(opd1) >>> opd2[4:0];
                end
            end
            ALU_MUL:  alu_res_o = prod_s[31:0];
            ALU_MULH: alu_res_o = opd_unsigned ? prod_u[63:32] : prod_s[63:32];
            ALU_DIV: begin
                if (opd2 == 32'd0) begin
                    alu_res_o = '1;
                end else if (opd_unsigned) begin
                    alu_res_o = opd1 / opd2;
                end else begin
                    alu_res_o = $signed(opd1) / $signed(opd2);
                end
            end
            ALU_MOD: begin
                if (opd2 == 32'd0) begin
                    alu_res_o = '1;
                end else if (opd_unsigned) begin
                    alu_res_o = opd1 % opd2;
                end else begin
                    alu_res_o = $signed(opd1) % $signed(opd2);
                end
            end
            ALU_LUI: alu_res_o = opd2;  // immediate already shifted.
            default: alu_res_o = 32'd0;
        endcase
    end

endmodule

// File: reg_file.sv
// ====================
// 32 x 32 general register file.
// two combinational reads, one write, r0 fixed at zero.
// ====================

`timescale 1ns/10ps

module reg_file (
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  logic [4:0]  raddr0_i,
    input  logic [4:0]  raddr1_i,
    output logic [31:0] rdata0_o,
    output logic [31:0] rdata1_o,
    input  logic        we_i,
    input  logic [4:0]  waddr_i,
    input  logic [31:0] wdata_i
);

    logic [31:0] regs [31:1];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != 5'd0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata0_o = (raddr0_i == 5'd0) ? 32'd0 : regs[raddr0_i];
    assign rdata1_o = (raddr1_i == 5'd0) ? 32'd0 : regs[raddr1_i];

endmodule

// File: inst_decoder.sv
// ====================
// LoongArch decoder for the integer subset.
// ====================

`timescale 1ns/10ps

module inst_decoder import exec_pkg::*; (
    input  logic [31:0]  inst_i,
    output decode_info_t decode_info_o
);

    alu_type_e alu_type;
    opd_type_e opd_type;
    logic      opd_unsigned;

    always_comb begin
        alu_type     = ALU_NONE;
        opd_type     = OPD_REG;
        opd_unsigned = 1'b0;

        case (inst_i[31:15])
            OP_ADD_W:  alu_type = ALU_ADD;
            OP_SUB_W:  alu_type = ALU_SUB;
            OP_SLT:    alu_type = ALU_SLT;
            OP_SLTU: begin
                alu_type     = ALU_SLT;
                opd_unsigned = 1'b1;
            end
            OP_NOR:    alu_type = ALU_NOR;
            OP_AND:    alu_type = ALU_AND;
            OP_OR:     alu_type = ALU_OR;
            OP_XOR:    alu_type = ALU_XOR;
            OP_SLL_W:  alu_type = ALU_SL;
            OP_SRL_W: begin
                alu_type     = ALU_SR;
                opd_unsigned = 1'b1;
            end
            OP_SRA_W:  alu_type = ALU_SR;
            OP_MUL_W:  alu_type = ALU_MUL;
            OP_MULH_W: alu_type = ALU_MULH;
            OP_MULH_WU: begin
                alu_type     = ALU_MULH;
                opd_unsigned = 1'b1;
            end
            OP_DIV_W:  alu_type = ALU_DIV;
            OP_MOD_W:  alu_type = ALU_MOD;
            OP_DIV_WU: begin
                alu_type     = ALU_DIV;
                opd_unsigned = 1'b1;
            end
            OP_MOD_WU: begin
                alu_type     = ALU_MOD;
                opd_unsigned = 1'b1;
            end
            OP_SLLI_W: begin
                alu_type = ALU_SL;
                opd_type = OPD_IMM_U5;
            end
            OP_SRLI_W: begin
                alu_type     = ALU_SR;
                opd_type     = OPD_IMM_U5;
                opd_unsigned = 1'b1;
            end
            OP_SRAI_W: begin
                alu_type = ALU_SR;
                opd_type = OPD_IMM_U5;
            end
            default: ;
        endcase

        // opcode groups do not overlap, so later matches never override.
        case (inst_i[31:22])
            OP_SLTI: begin
                alu_type = ALU_SLT;
                opd_type = OPD_IMM_S12;
            end
            OP_SLTUI: begin
                alu_type     = ALU_SLT;
                opd_type     = OPD_IMM_S12;  // sign extended, compared unsigned.
                opd_unsigned = 1'b1;
            end
            OP_ADDI_W: begin
                alu_type = ALU_ADD;
                opd_type = OPD_IMM_S12;
            end
            OP_ANDI: begin
                alu_type = ALU_AND;
                opd_type = OPD_IMM_U12;
            end
            OP_ORI: begin
                alu_type = ALU_OR;
                opd_type = OPD_IMM_U12;
            end
            OP_XORI: begin
                alu_type = ALU_XOR;
                opd_type = OPD_IMM_U12;
            end
            default: ;
        endcase

        case (inst_i[31:25])
            OP_LU12I_W: begin
                alu_type = ALU_LUI;
                opd_type = OPD_IMM_S20;
            end
            OP_PCADDU12I: begin
                alu_type = ALU_ADD;
                opd_type = OPD_IMM_S20;  // pc replaces rj in the ALU.
            end
            default: ;
        endcase
    end

    assign decode_info_o.alu_type     = alu_type;
    assign decode_info_o.opd_type     = opd_type;
    assign decode_info_o.opd_unsigned = opd_unsigned;
    assign decode_info_o.inst25_0     = inst_i[25:0];
    assign decode_info_o.rj           = inst_i[9:5];
    assign decode_info_o.rk           = inst_i[14:10];
    assign decode_info_o.rd           = inst_i[4:0];
    assign decode_info_o.wb_en        = (alu_type != ALU_NONE);  // unknown words write nothing.

endmodule

// File: inst_buffer.sv
// ====================
// instruction request FIFO.
// circular buffer with one upstream credit returned per pop.
// ====================

`timescale 1ns/10ps

module inst_buffer import exec_pkg::*; #(
    parameter int BUF_DEPTH = 4
) (
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      inst_valid_i,
    input  inst_req_t inst_req_i,
    input  logic      pop_i,
    output inst_req_t head_o,
    output logic      empty_o,
    output logic      inst_credit_o
);

    localparam int AW = $clog2(BUF_DEPTH);

    inst_req_t       mem [BUF_DEPTH];
    logic [AW-1:0]   wr_ptr_q, rd_ptr_q;
    logic [AW:0]     count_q;
    logic            full;

    assign full    = (count_q == (AW+1)'(BUF_DEPTH));
    assign empty_o = (count_q == '0);
    assign head_o  = mem[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (inst_valid_i) begin
            mem[wr_ptr_q] <= inst_req_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q      <= '0;
            rd_ptr_q      <= '0;
            count_q       <= '0;
            inst_credit_o <= 1'b0;
        end else begin
            if (inst_valid_i) wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps at the power-of-two depth.
            if (pop_i) rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({inst_valid_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            inst_credit_o <= pop_i;  // one credit back per entry leaving.
        end
    end

    // sender credits keep the FIFO from overflowing.
    a_no_overflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        inst_valid_i |-> !full);
    a_no_underflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        pop_i |-> !empty_o);

endmodule

// File: exec_pkg.sv
// ====================
// shared types for the integer execute stage.
// ALU, operand and FSM enums, the decode, request and result structs,
// and the LoongArch opcode fields matched by the decoder.
// ====================

package exec_pkg;

    typedef enum logic [3:0] {
        ALU_NONE, ALU_ADD, ALU_SUB, ALU_SLT, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SL, ALU_SR, ALU_MUL, ALU_MULH, ALU_DIV, ALU_MOD, ALU_LUI
    } alu_type_e;

    typedef enum logic [2:0] {
        OPD_REG, OPD_IMM_U5, OPD_IMM_S12, OPD_IMM_U12, OPD_IMM_S20
    } opd_type_e;

    typedef enum logic [1:0] {
        ST_IDLE, ST_RUN, ST_STALL
    } issue_state_e;

    typedef struct packed {
        alu_type_e   alu_type;
        opd_type_e   opd_type;
        logic        opd_unsigned;  // unsigned compare, shift, multiply or divide.
        logic [25:0] inst25_0;      // raw immediate bits.
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [4:0]  rd;
        logic        wb_en;
    } decode_info_t;

    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] pc;
    } inst_req_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] value;
    } exe_res_t;

    // ==================== 3R and shift-immediate forms, inst[31:15].
    localparam logic [16:0] OP_ADD_W   = 17'h00020;
    localparam logic [16:0] OP_SUB_W   = 17'h00022;
    localparam logic [16:0] OP_SLT     = 17'h00024;
    localparam logic [16:0] OP_SLTU    = 17'h00025;
    localparam logic [16:0] OP_NOR     = 17'h00028;
    localparam logic [16:0] OP_AND     = 17'h00029;
    localparam logic [16:0] OP_OR      = 17'h0002a;
    localparam logic [16:0] OP_XOR     = 17'h0002b;
    localparam logic [16:0] OP_SLL_W   = 17'h0002e;
    localparam logic [16:0] OP_SRL_W   = 17'h0002f;
    localparam logic [16:0] OP_SRA_W   = 17'h00030;
    localparam logic [16:0] OP_MUL_W   = 17'h00038;
    localparam logic [16:0] OP_MULH_W  = 17'h00039;
    localparam logic [16:0] OP_MULH_WU = 17'h0003a;
    localparam logic [16:0] OP_DIV_W   = 17'h00040;
    localparam logic [16:0] OP_MOD_W   = 17'h00041;
    localparam logic [16:0] OP_DIV_WU  = 17'h00042;
    localparam logic [16:0] OP_MOD_WU  = 17'h00043;
    localparam logic [16:0] OP_SLLI_W  = 17'h00081;
    localparam logic [16:0] OP_SRLI_W  = 17'h00089;
    localparam logic [16:0] OP_SRAI_W  = 17'h00091;

    // ==================== 2RI12 forms, inst[31:22].
    localparam logic [9:0] OP_SLTI    = 10'h008;
    localparam logic [9:0] OP_SLTUI   = 10'h009;
    localparam logic [9:0] OP_ADDI_W  = 10'h00a;
    localparam logic [9:0] OP_ANDI    = 10'h00d;
    localparam logic [9:0] OP_ORI     = 10'h00e;
    localparam logic [9:0] OP_XORI    = 10'h00f;

    // ==================== 1RI20 forms, inst[31:25].
    localparam logic [6:0] OP_LU12I_W   = 7'h0a;
    localparam logic [6:0] OP_PCADDU12I = 7'h0e;

endpackage
